// File: hw/match_cfg.svh
`ifndef MATCH_CFG_SVH
`define MATCH_CFG_SVH

// number of job PEs sharing the history memory
`define NUM_JOB_PE 4

// history word address width, memory depth is 2**ADDR_WIDTH words
`define ADDR_WIDTH 8

// bytes per history word
`define WORD_BYTES 4

// word pairs compared per batch at most
`define MAX_MATCH_WORDS 4

// match length width, holds WORD_BYTES*MAX_MATCH_WORDS
`define ML_BITS 5

// job index width
`define JOB_ID_BITS 2

`endif

// File: hw/match_pkg.sv
`include "match_cfg.svh"

package match_pkg;

  typedef logic [`ADDR_WIDTH-1:0] hist_addr_t;
  typedef logic [`JOB_ID_BITS-1:0] job_id_t;

  // byte 0 is compared first
  typedef logic [`WORD_BYTES-1:0][7:0] hist_word_t;

  typedef struct packed {
    hist_addr_t head_addr;
    logic       cand_valid;
    hist_addr_t cand_addr;
    logic       delim;
  } hash_batch_t;

  typedef struct packed {
    logic [`ML_BITS-1:0] ml;
    hist_addr_t          offset;
    logic                delim;
  } seq_t;

  // successor on the job ring
  function automatic job_id_t next_job(input job_id_t id);
    if (int'(id) == `NUM_JOB_PE - 1) begin
      return '0;
    end
    return id + 1'b1;
  endfunction

endpackage

// File: hw/pipe_slice.sv
module pipe_slice #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_valid,
  input  T     i_data,
  output logic o_ready,
  output logic o_valid,
  output T     o_data,
  input  logic i_ready
);

  logic valid_q;
  T     data_q;

  // take new data when empty or draining this cycle
  assign o_ready = !valid_q || i_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_ready && i_valid) begin
      data_q <= i_data;
    end
  end

  assign o_valid = valid_q;
  assign o_data  = data_q;

endmodule

// File: hw/batch_dispatch.sv
`include "match_cfg.svh"

module batch_dispatch
  import match_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_valid,
  input  hash_batch_t            i_batch,
  output logic                   o_ready,
  output logic [`NUM_JOB_PE-1:0] o_job_valid,
  output hash_batch_t            o_job_batch,
  input  logic [`NUM_JOB_PE-1:0] i_job_idle
);

  job_id_t tgt_q;
  logic    fire;

  // batch k always goes to job k mod NUM_JOB_PE
  // so a busy target stalls the input
  assign o_ready = i_job_idle[tgt_q];
  assign fire    = i_valid && o_ready;

  // all jobs see the same payload, only the target gets a start
  assign o_job_batch = i_batch;

  always_comb begin
    o_job_valid        = '0;
    o_job_valid[tgt_q] = fire;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tgt_q <= '0;
    end else if (fire) begin
      tgt_q <= next_job(tgt_q);
    end
  end

endmodule

// File: hw/job_pe.sv
`include "match_cfg.svh"

module job_pe
  import match_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_start,
  input  hash_batch_t i_batch,
  output logic        o_idle,
  output logic        o_rd_req,
  output hist_addr_t  o_rd_addr,
  input  logic        i_rd_gnt,
  input  hist_word_t  i_rd_data,
  output logic        o_done,
  output seq_t        o_seq,
  input  logic        i_taken
);

  localparam int WIDX_BITS = (`MAX_MATCH_WORDS > 1) ? $clog2(`MAX_MATCH_WORDS) : 1;

  typedef enum logic [2:0] {
    S_IDLE,
    S_REQ_HEAD,
    S_WAIT_HEAD,
    S_REQ_CAND,
    S_WAIT_CAND,
    S_DONE
  } state_t;

  state_t               state_q;
  hash_batch_t          batch_q;
  hist_word_t           head_word_q;
  logic [`ML_BITS-1:0]  ml_q;
  logic [WIDX_BITS-1:0] widx_q;
  logic [`ML_BITS-1:0]  eq_cnt;
  logic                 all_eq;
  logic                 last_word;

  // leading equal bytes, candidate word arrives on i_rd_data
  always_comb begin
    eq_cnt = '0;
    all_eq = 1'b1;
    for (int b = 0; b < `WORD_BYTES; b++) begin
      if (all_eq && head_word_q[b] == i_rd_data[b]) begin
        eq_cnt = eq_cnt + 1'b1;
      end else begin
        all_eq = 1'b0;
      end
    end
  end

  assign last_word = (int'(widx_q) == `MAX_MATCH_WORDS - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (i_start) begin
            state_q <= i_batch.cand_valid ? S_REQ_HEAD : S_DONE;
          end
        end
        S_REQ_HEAD: if (i_rd_gnt) state_q <= S_WAIT_HEAD;
        S_WAIT_HEAD: state_q <= S_REQ_CAND;
        S_REQ_CAND: if (i_rd_gnt) state_q <= S_WAIT_CAND;
        S_WAIT_CAND: begin
          // next pair only after a full word match
          state_q <= (all_eq && !last_word) ? S_REQ_HEAD : S_DONE;
        end
        S_DONE: if (i_taken) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && i_start) begin
      batch_q <= i_batch;
      ml_q    <= '0;
      widx_q  <= '0;
    end
    if (state_q == S_WAIT_HEAD) begin
      head_word_q <= i_rd_data;
    end
    if (state_q == S_WAIT_CAND) begin
      ml_q   <= ml_q + eq_cnt;
      widx_q <= widx_q + 1'b1;
    end
  end

  assign o_idle    = (state_q == S_IDLE);
  assign o_done    = (state_q == S_DONE);
  assign o_rd_req  = (state_q == S_REQ_HEAD) || (state_q == S_REQ_CAND);
  assign o_rd_addr = ((state_q == S_REQ_HEAD) ? batch_q.head_addr : batch_q.cand_addr)
                     + hist_addr_t'(widx_q);

  assign o_seq = '{
    ml:     ml_q,
    offset: batch_q.head_addr - batch_q.cand_addr,
    delim:  batch_q.delim
  };

endmodule

// File: hw/history_ram.sv
`include "match_cfg.svh"

module history_ram
  import match_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              i_we,
  input  hist_addr_t                        i_waddr,
  input  hist_word_t                        i_wdata,
  input  logic       [`NUM_JOB_PE-1:0]      i_rd_req,
  input  hist_addr_t [`NUM_JOB_PE-1:0]      i_rd_addr,
  output logic       [`NUM_JOB_PE-1:0]      o_rd_gnt,
  output hist_word_t                        o_rd_data
);

  hist_word_t mem [2**`ADDR_WIDTH];
  hist_word_t rd_data_q;
  job_id_t    ptr_q;
  job_id_t    scan;
  job_id_t    win;
  logic       found;

  // rotating priority from ptr_q, a write cycle blocks all reads
  always_comb begin
    win   = ptr_q;
    found = 1'b0;
    for (int k = 0; k < `NUM_JOB_PE; k++) begin
      scan = job_id_t'((int'(ptr_q) + k) % `NUM_JOB_PE);
      if (!found && !i_we && i_rd_req[scan]) begin
        found = 1'b1;
        win   = scan;
      end
    end
    o_rd_gnt = '0;
    if (found) begin
      o_rd_gnt[win] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= next_job(win);
    end
  end

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
    if (found) begin
      rd_data_q <= mem[i_rd_addr[win]];
    end
  end

  // valid the cycle after the grant
  assign o_rd_data = rd_data_q;

endmodule

// File: hw/seq_token_ring.sv
`include "match_cfg.svh"

module seq_token_ring
  import match_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`NUM_JOB_PE-1:0]      i_done,
  input  seq_t [`NUM_JOB_PE-1:0]      i_seq,
  output logic [`NUM_JOB_PE-1:0]      o_taken,
  output logic                        o_seq_valid,
  output seq_t                        o_seq,
  input  logic                        i_seq_ready
);

  job_id_t tok_q;
  logic    slice_ready;
  logic    take;

  // only the token holder may emit, which keeps batch order
  assign take = i_done[tok_q] && slice_ready;

  always_comb begin
    o_taken        = '0;
    o_taken[tok_q] = take;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tok_q <= '0;
    end else if (take) begin
      tok_q <= next_job(tok_q);
    end
  end

  pipe_slice #(
    .T(seq_t)
  ) u_out_slice (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_done[tok_q]),
    .i_data (i_seq[tok_q]),
    .o_ready(slice_ready),
    .o_valid(o_seq_valid),
    .o_data (o_seq),
    .i_ready(i_seq_ready)
  );

endmodule

// File: hw/match_engine.sv
`include "match_cfg.svh"

module match_engine
  import match_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  logic        i_batch_valid,
  input  hash_batch_t i_batch,
  output logic        o_batch_ready,

  output logic        o_seq_valid,
  output seq_t        o_seq,
  input  logic        i_seq_ready,

  // history write port
  input  logic        i_hist_we,
  input  hist_addr_t  i_hist_waddr,
  input  hist_word_t  i_hist_wdata
);

  logic                              bq_valid;
  hash_batch_t                       bq_data;
  logic                              bq_ready;

  logic       [`NUM_JOB_PE-1:0]      job_valid;
  hash_batch_t                       job_batch;
  logic       [`NUM_JOB_PE-1:0]      job_idle;
  logic       [`NUM_JOB_PE-1:0]      job_done;
  seq_t       [`NUM_JOB_PE-1:0]      job_seq;
  logic       [`NUM_JOB_PE-1:0]      job_taken;

  logic       [`NUM_JOB_PE-1:0]      rd_req;
  hist_addr_t [`NUM_JOB_PE-1:0]      rd_addr;
  logic       [`NUM_JOB_PE-1:0]      rd_gnt;
  hist_word_t                        rd_data;

  pipe_slice #(
    .T(hash_batch_t)
  ) u_in_slice (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_batch_valid),
    .i_data (i_batch),
    .o_ready(o_batch_ready),
    .o_valid(bq_valid),
    .o_data (bq_data),
    .i_ready(bq_ready)
  );

  batch_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_valid    (bq_valid),
    .i_batch    (bq_data),
    .o_ready    (bq_ready),
    .o_job_valid(job_valid),
    .o_job_batch(job_batch),
    .i_job_idle (job_idle)
  );

  for (genvar g = 0; g < `NUM_JOB_PE; g++) begin : g_job
    job_pe u_job (
      .clk      (clk),
      .rst_n    (rst_n),
      .i_start  (job_valid[g]),
      .i_batch  (job_batch),
      .o_idle   (job_idle[g]),
      .o_rd_req (rd_req[g]),
      .o_rd_addr(rd_addr[g]),
      .i_rd_gnt (rd_gnt[g]),
      .i_rd_data(rd_data),
      .o_done   (job_done[g]),
      .o_seq    (job_seq[g]),
      .i_taken  (job_taken[g])
    );
  end

  history_ram u_hist (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_we     (i_hist_we),
    .i_waddr  (i_hist_waddr),
    .i_wdata  (i_hist_wdata),
    .i_rd_req (rd_req),
    .i_rd_addr(rd_addr),
    .o_rd_gnt (rd_gnt),
    .o_rd_data(rd_data)
  );

  seq_token_ring u_ring (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_done     (job_done),
    .i_seq      (job_seq),
    .o_taken    (job_taken),
    .o_seq_valid(o_seq_valid),
    .o_seq      (o_seq),
    .i_seq_ready(i_seq_ready)
  );

endmodule

// File: tb/tb_match_engine.sv
`include "match_cfg.svh"

module tb_match_engine
  import match_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SEND_TIMEOUT  = 500;
  localparam int DRAIN_TIMEOUT = 5000;
  localparam int FULL_ML       = `WORD_BYTES * `MAX_MATCH_WORDS;

  logic        clk;
  logic        rst_n;
  logic        i_batch_valid;
  hash_batch_t i_batch;
  logic        o_batch_ready;
  logic        o_seq_valid;
  seq_t        o_seq;
  logic        i_seq_ready;
  logic        i_hist_we;
  hist_addr_t  i_hist_waddr;
  hist_word_t  i_hist_wdata;

  hist_word_t  model_mem [2**`ADDR_WIDTH];
  seq_t        exp_q [$];
  hist_addr_t  pair_head [4];
  hist_addr_t  pair_cand [4];
  logic [31:0] stim_state;
  logic [31:0] ready_state;
  logic        stall_en;
  logic        aborted;
  logic        hold_q;
  seq_t        held_seq;
  seq_t        exp_seq;
  int          mismatch_cnt;
  int          other_cnt;
  int          recv_cnt;

  match_engine u_match_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_batch_valid(i_batch_valid),
    .i_batch      (i_batch),
    .o_batch_ready(o_batch_ready),
    .o_seq_valid  (o_seq_valid),
    .o_seq        (o_seq),
    .i_seq_ready  (i_seq_ready),
    .i_hist_we    (i_hist_we),
    .i_hist_waddr (i_hist_waddr),
    .i_hist_wdata (i_hist_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg(inout logic [31:0] st);
    st = st * 32'd1664525 + 32'd1013904223;
    return st;
  endfunction

  // leading equal bytes over the word pairs, byte 0 first
  function automatic seq_t model_seq(input hash_batch_t b);
    seq_t       s;
    int         ml;
    logic       stop;
    hist_addr_t ha;
    hist_addr_t ca;
    ml   = 0;
    stop = 1'b0;
    if (b.cand_valid) begin
      for (int w = 0; w < `MAX_MATCH_WORDS; w++) begin
        ha = b.head_addr + hist_addr_t'(w);
        ca = b.cand_addr + hist_addr_t'(w);
        for (int k = 0; k < `WORD_BYTES; k++) begin
          if (!stop && model_mem[ha][k] == model_mem[ca][k]) begin
            ml++;
          end else begin
            stop = 1'b1;
          end
        end
      end
    end
    s.ml     = ml[`ML_BITS-1:0];
    s.offset = b.head_addr - b.cand_addr;
    s.delim  = b.delim;
    return s;
  endfunction

  function automatic hash_batch_t rand_batch();
    logic [31:0] r;
    hash_batch_t b;
    r            = lcg(stim_state);
    b.head_addr  = r[7:0];
    b.cand_addr  = r[15:8];
    b.cand_valid = (r[19:17] != 3'b000);
    b.delim      = r[24];
    return b;
  endfunction

  task automatic write_word(input hist_addr_t addr, input hist_word_t data);
    i_hist_we       = 1'b1;
    i_hist_waddr    = addr;
    i_hist_wdata    = data;
    model_mem[addr] = data;
    @(posedge clk);
    #1;
    i_hist_we = 1'b0;
  endtask

  // candidate region a few words away whose first p bytes copy the head
  task automatic plant_match(input hist_addr_t head, input int p, output hist_addr_t cand);
    logic [31:0] r;
    hist_word_t  w;
    hist_word_t  hw;
    int          j;
    r    = lcg(stim_state);
    cand = head + hist_addr_t'(4 + int'(r[15:8]) % 248);
    for (int i = 0; i < `MAX_MATCH_WORDS; i++) begin
      w  = lcg(stim_state);
      hw = model_mem[head + hist_addr_t'(i)];
      for (int k = 0; k < `WORD_BYTES; k++) begin
        j = i * `WORD_BYTES + k;
        if (j < p) begin
          w[k] = hw[k];
        end else if (j == p) begin
          w[k] = hw[k] ^ (r[7:0] | 8'h01);
        end
      end
      write_word(cand + hist_addr_t'(i), w);
    end
  endtask

  task automatic plant_pairs();
    logic [31:0] r;
    hist_addr_t  c;
    for (int s = 0; s < 4; s++) begin
      r = lcg(stim_state);
      plant_match(r[7:0], int'(r[12:8]) % (FULL_ML + 1), c);
      pair_head[s] = r[7:0];
      pair_cand[s] = c;
    end
  endtask

  task automatic send_batch(input hash_batch_t b);
    int   cnt;
    logic taken;
    if (!aborted) begin
      exp_q.push_back(model_seq(b));
      i_batch_valid = 1'b1;
      i_batch       = b;
      taken         = 1'b0;
      cnt           = 0;
      while (!taken && cnt < SEND_TIMEOUT) begin
        @(negedge clk);
        taken = o_batch_ready;
        @(posedge clk);
        #1;
        cnt++;
      end
      i_batch_valid = 1'b0;
      if (!taken) begin
        other_cnt++;
        aborted = 1'b1;
        $display("batch was not accepted within %0d cycles at %0t", SEND_TIMEOUT, $time);
      end
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (!aborted && exp_q.size() != 0 && cnt < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    @(posedge clk);
    #1;
    if (!aborted && exp_q.size() != 0) begin
      other_cnt++;
      aborted = 1'b1;
      $display("%0d records still missing after %0d cycles", exp_q.size(), DRAIN_TIMEOUT);
    end
  endtask

  // back-to-back batches, a quarter of them reuse a planted pair
  task automatic run_burst(input int n);
    logic [31:0] r;
    hash_batch_t b;
    int          s;
    for (int i = 0; i < n; i++) begin
      r = lcg(stim_state);
      b = rand_batch();
      if (r[31:30] == 2'b00) begin
        s            = int'(r[29:28]);
        b.head_addr  = pair_head[s];
        b.cand_addr  = pair_cand[s];
        b.cand_valid = 1'b1;
      end
      send_batch(b);
    end
  endtask

  // sink readiness, random while stalls are enabled
  initial begin
    logic [31:0] r;
    ready_state = 32'h1a98;
    i_seq_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      r           = lcg(ready_state);
      i_seq_ready = stall_en ? r[23] : 1'b1;
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (hold_q) begin
        assert (o_seq_valid && o_seq == held_seq) else begin
          mismatch_cnt++;
          $display("Mismatch at %0t: output record changed while stalled", $time);
        end
      end
      if (o_seq_valid && i_seq_ready) begin
        assert (exp_q.size() > 0) else begin
          other_cnt++;
          $display("an output record arrived at %0t with none expected", $time);
        end
        if (exp_q.size() > 0) begin
          exp_seq = exp_q.pop_front();
          recv_cnt++;
          assert (o_seq == exp_seq) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: record %0d ml=%0d off=%h delim=%b, expected %0d %h %b",
                     $time, recv_cnt, o_seq.ml, o_seq.offset, o_seq.delim,
                     exp_seq.ml, exp_seq.offset, exp_seq.delim);
          end
        end
      end
      hold_q   = o_seq_valid && !i_seq_ready;
      held_seq = o_seq;
    end
  end

  initial begin
    logic [31:0] r;
    hist_addr_t  c;
    rst_n         = 1'b0;
    i_batch_valid = 1'b0;
    i_batch       = '0;
    i_hist_we     = 1'b0;
    i_hist_waddr  = '0;
    i_hist_wdata  = '0;
    stim_state    = 32'h1a98;
    stall_en      = 1'b0;
    aborted       = 1'b0;
    hold_q        = 1'b0;
    mismatch_cnt  = 0;
    other_cnt     = 0;
    recv_cnt      = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (!o_seq_valid && o_batch_ready) else begin
      mismatch_cnt++;
      $display("Mismatch at %0t: valid=%b ready=%b after reset", $time, o_seq_valid, o_batch_ready);
    end
    @(posedge clk);
    #1;

    for (int a = 0; a < 2**`ADDR_WIDTH; a++) begin
      write_word(hist_addr_t'(a), lcg(stim_state));
    end
    // full-length matches
    for (int i = 0; i < 6; i++) begin
      r = lcg(stim_state);
      plant_match(r[7:0], FULL_ML, c);
      send_batch('{head_addr: r[7:0], cand_valid: 1'b1, cand_addr: c, delim: r[8]});
      wait_drain();
    end
    // prefixes of every length, some crossing word boundaries
    for (int i = 0; i < 17; i++) begin
      r = lcg(stim_state);
      plant_match(r[7:0], i, c);
      send_batch('{head_addr: r[7:0], cand_valid: 1'b1, cand_addr: c, delim: r[8]});
      wait_drain();
    end

    plant_pairs();
    stall_en = 1'b1;
    run_burst(80);
    wait_drain();

    // new contents after the queue is empty
    for (int i = 0; i < 64; i++) begin
      r = lcg(stim_state);
      write_word(r[7:0], lcg(stim_state));
    end
    plant_pairs();
    run_burst(48);
    stall_en = 1'b0;
    wait_drain();

    assert (aborted || (!o_seq_valid && o_batch_ready)) else begin
      other_cnt++;
      $display("engine still busy or holding a record after the last one at %0t", $time);
    end
    $display("%0d records, %0d mismatches, %0d other errors", recv_cnt, mismatch_cnt, other_cnt);
    if (mismatch_cnt + other_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+hw
hw/match_pkg.sv
hw/pipe_slice.sv
hw/batch_dispatch.sv
hw/job_pe.sv
hw/history_ram.sv
hw/seq_token_ring.sv
hw/match_engine.sv
tb/tb_match_engine.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_match_engine -f src.f -o sim_match_engine \
  && ./obj_dir/sim_match_engine | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
